/* verilog/sdram_pkg.sv */
// Shared widths, SDRAM command codes and the A-bus word layout, imported by every RTL block
package sdram_pkg;

    localparam int DATA_W  = 16;
    localparam int DQM_W   = DATA_W / 8;
    localparam int ROW_W   = 13;
    localparam int COL_W   = 9;
    localparam int BANK_W  = 2;
    localparam int HADDR_W = BANK_W + ROW_W + COL_W;   // Bank | row | column from the top down

    // Bit order is cs_n, ras_n, cas_n, we_n
    localparam logic [3:0] CMD_NOP       = 4'b1111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_MODE      = 4'b0000;

    // One A-bus word, read as mode register contents or as a column address
    typedef union packed {
        struct packed {
            logic [ROW_W-8:0] op_mode;      // A12..A7
            logic [2:0]       cas_lat;
            logic             burst_type;
            logic [2:0]       burst_len;
        } mode;
        struct packed {
            logic [ROW_W-COL_W-3:0] rsvd_hi;
            logic                   ap;     // A10, auto-precharge or precharge all
            logic                   rsvd_lo;
            logic [COL_W-1:0]       col;
        } column;
    } sdram_a_u;

    // CAS 2, sequential, burst length 1
    localparam logic [ROW_W-1:0] MODE_CAS2 = {{(ROW_W-7){1'b0}}, 3'd2, 1'b0, 3'b000};

endpackage

/* verilog/sdram_ifs.sv */
// Internal buses of the controller: host requests into the sequencer, commands out to the pins
`timescale 1ns/1ps

interface req_bus;
    import sdram_pkg::*;

    logic               valid;
    logic               take;
    logic               we;
    logic [HADDR_W-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [DQM_W-1:0]   ds;

    // Item passes when valid and take are both high
    modport source (output valid, we, addr, wdata, ds, input take);
    modport sink (input valid, we, addr, wdata, ds, output take);
endinterface

interface cmd_bus;
    import sdram_pkg::*;

    logic [3:0]        cmd;
    logic [BANK_W-1:0] ba;
    sdram_a_u          a;
    logic [DQM_W-1:0]  dqm;
    logic [DATA_W-1:0] wdata;
    logic              drive;       // Write data goes out with this command
    logic              rd_issue;    // Marks a READ for the capture pipe

    modport source (output cmd, ba, a, dqm, wdata, drive, rd_issue);
    modport sink (input cmd, ba, a, dqm, wdata, drive, rd_issue);
endinterface

/* verilog/host_port.sv */
// Host request port, takes req/ack requests and holds one in a slot for the sequencer
`timescale 1ns/1ps

module host_port (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req,
    input  logic                          we,
    input  logic [sdram_pkg::HADDR_W-1:0] addr,
    input  logic [sdram_pkg::DATA_W-1:0]  wdata,
    input  logic [sdram_pkg::DQM_W-1:0]   ds,
    output logic                          ack,
    req_bus.source                        bus
);

    logic load;

    // A request still held after its ack is not loaded twice
    assign load = req && !ack && (!bus.valid || bus.take);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack       <= 1'b0;
            bus.valid <= 1'b0;
        end else begin
            ack <= load;
            if (load) begin
                bus.valid <= 1'b1;
            end else if (bus.take) begin
                bus.valid <= 1'b0;      // Handed to the sequencer
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bus.we    <= we;
            bus.addr  <= addr;
            bus.wdata <= wdata;
            bus.ds    <= ds;
        end
    end

    // A full slot keeps its request and gives no ack until the sequencer takes it
    slot_hold_a: assert property (@(posedge clk) disable iff (!resetn)
        bus.valid && !bus.take |=>
            !ack && bus.valid && $stable(bus.addr) && $stable(bus.wdata) && $stable(bus.we));

endmodule

/* verilog/init_sequencer.sv */
// Power-up command order for the SDRAM, raises done once the mode register is set
`timescale 1ns/1ps

module init_sequencer #(
    parameter int T_RP  = 2,
    parameter int T_RC  = 6,
    parameter int T_MRD = 2
) (
    input  logic                clk,
    input  logic                resetn,
    output logic [3:0]          cmd,
    output sdram_pkg::sdram_a_u a,
    output logic                done
);
    import sdram_pkg::*;

    localparam int LAST = T_RP + 2 * T_RC + T_MRD;
    localparam int CW   = $clog2(LAST + 2);

    logic [CW-1:0] step;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            step <= '0;
            cmd  <= CMD_NOP;
            a    <= '0;
            done <= 1'b0;
        end else if (!done) begin
            step <= step + 1'b1;
            cmd  <= CMD_NOP;
            a    <= '0;
            if (step == '0) begin
                cmd         <= CMD_PRECHARGE;
                a.column.ap <= 1'b1;    // All banks
            end else if (step == CW'(T_RP) || step == CW'(T_RP + T_RC)) begin
                cmd <= CMD_REFRESH;
            end else if (step == CW'(T_RP + 2 * T_RC)) begin
                cmd    <= CMD_MODE;
                a.mode <= MODE_CAS2;
            end else if (step == CW'(LAST)) begin
                done <= 1'b1;           // Held until the next reset
            end
        end
    end

    // Once done, this block stays silent
    quiet_after_done_a: assert property (@(posedge clk) disable iff (!resetn)
        done |=> (done && cmd == CMD_NOP));

endmodule

/* verilog/sdram_sequencer.sv */
// Command scheduler, chooses between refresh and host access and times each SDRAM command
`timescale 1ns/1ps

module sdram_sequencer #(
    parameter int CAS_LATENCY      = 2,
    parameter int T_RP             = 2,
    parameter int T_RCD            = 2,
    parameter int T_RC             = 6,
    parameter int T_WR             = 2,
    parameter int T_MRD            = 2,
    parameter int REFRESH_INTERVAL = 501
) (
    input  logic    clk,
    input  logic    resetn,
    req_bus.sink    req,
    cmd_bus.source  cmd_out
);
    import sdram_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_REFRESH  = 2'd1;
    localparam logic [1:0] ST_ACTIVATE = 2'd2;
    localparam logic [1:0] ST_RECOVER  = 2'd3;
    localparam int RW = $clog2(REFRESH_INTERVAL + 1);

    logic [3:0]        init_cmd;
    sdram_a_u          init_a;
    logic              init_done;

    logic [1:0]        state;
    logic [7:0]        wait_cnt;
    logic [RW-1:0]     ref_cnt;
    logic              refresh_due;
    logic              start_ref;
    logic              start_acc;
    logic              issue_rw;

    logic [3:0]        acc_cmd;
    logic [DQM_W-1:0]  acc_dqm;
    logic              acc_drive;
    logic              acc_rd_issue;
    logic [BANK_W-1:0] acc_ba;
    sdram_a_u          acc_a;
    logic [COL_W-1:0]  acc_col;
    logic              acc_we;
    logic [DATA_W-1:0] acc_wdata;

    init_sequencer #(
        .T_RP  (T_RP),
        .T_RC  (T_RC),
        .T_MRD (T_MRD)
    ) init_i (
        .clk    (clk),
        .resetn (resetn),
        .cmd    (init_cmd),
        .a      (init_a),
        .done   (init_done)
    );

    assign refresh_due = (ref_cnt == RW'(REFRESH_INTERVAL));
    assign start_ref   = (state == ST_IDLE) && init_done && refresh_due;   // Refresh wins
    assign req.take    = (state == ST_IDLE) && init_done && !refresh_due;
    assign start_acc   = req.take && req.valid;
    assign issue_rw    = (state == ST_ACTIVATE) && (wait_cnt == '0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state        <= ST_IDLE;
            wait_cnt     <= '0;
            ref_cnt      <= '0;
            acc_cmd      <= CMD_NOP;
            acc_dqm      <= '1;
            acc_drive    <= 1'b0;
            acc_rd_issue <= 1'b0;
        end else begin
            acc_cmd      <= CMD_NOP;
            acc_drive    <= 1'b0;
            acc_rd_issue <= 1'b0;

            if (start_ref) begin
                ref_cnt <= '0;
            end else if (!refresh_due) begin
                ref_cnt <= ref_cnt + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (start_ref) begin
                        acc_cmd  <= CMD_REFRESH;
                        state    <= ST_REFRESH;
                        wait_cnt <= 8'(T_RC - 2);   // Next command lands T_RC later
                    end else if (start_acc) begin
                        acc_cmd  <= CMD_ACTIVE;
                        acc_dqm  <= req.we ? ~req.ds : '0;
                        state    <= ST_ACTIVATE;
                        wait_cnt <= 8'(T_RCD - 1);
                    end
                end
                ST_ACTIVATE: begin
                    if (wait_cnt == '0) begin
                        acc_cmd      <= acc_we ? CMD_WRITE : CMD_READ;
                        acc_drive    <= acc_we;
                        acc_rd_issue <= !acc_we;
                        state        <= ST_RECOVER;
                        // Auto-precharge runs in the background
                        wait_cnt     <= acc_we ? 8'(T_WR + T_RP - 2)
                                               : 8'(CAS_LATENCY + T_RP - 2);
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ST_REFRESH, ST_RECOVER: begin
                    if (wait_cnt == '0) begin
                        state   <= ST_IDLE;
                        acc_dqm <= '1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and data of the access in progress
    always_ff @(posedge clk) begin
        if (start_acc) begin
            acc_ba    <= req.addr[HADDR_W-1 -: BANK_W];
            acc_a     <= req.addr[COL_W +: ROW_W];      // Row for ACTIVE
            acc_col   <= req.addr[COL_W-1:0];
            acc_we    <= req.we;
            acc_wdata <= req.wdata;
        end else if (issue_rw) begin
            acc_a           <= '0;
            acc_a.column.col <= acc_col;
            acc_a.column.ap  <= 1'b1;
        end
    end

    // Init owns the bus until done
    assign cmd_out.cmd      = init_done ? acc_cmd : init_cmd;
    assign cmd_out.a        = init_done ? acc_a : init_a;
    assign cmd_out.ba       = init_done ? acc_ba : '0;
    assign cmd_out.dqm      = init_done ? acc_dqm : '1;
    assign cmd_out.wdata    = acc_wdata;
    assign cmd_out.drive    = acc_drive;
    assign cmd_out.rd_issue = acc_rd_issue;

    rcd_a: assert property (@(posedge clk) disable iff (!resetn)
        (cmd_out.cmd == CMD_READ || cmd_out.cmd == CMD_WRITE)
            |-> $past(cmd_out.cmd, T_RCD) == CMD_ACTIVE);

endmodule

/* verilog/sdram_phy.sv */
// SDRAM pin side, registers the command bus onto the pins and captures read data
`timescale 1ns/1ps

module sdram_phy #(
    parameter int CAS_LATENCY = 2
) (
    input  logic                         clk,
    input  logic                         resetn,
    cmd_bus.sink                         cmd_in,
    inout  wire  [sdram_pkg::DATA_W-1:0] sdram_dq,
    output logic [sdram_pkg::ROW_W-1:0]  sdram_a,
    output logic [sdram_pkg::BANK_W-1:0] sdram_ba,
    output logic [sdram_pkg::DQM_W-1:0]  sdram_dqm,
    output logic                         sdram_cs_n,
    output logic                         sdram_ras_n,
    output logic                         sdram_cas_n,
    output logic                         sdram_we_n,
    output logic                         sdram_cke,
    output logic [sdram_pkg::DATA_W-1:0] rdata,
    output logic                         rvalid
);
    import sdram_pkg::*;

    logic                   dq_oe;
    logic [DATA_W-1:0]      dq_out;
    logic [CAS_LATENCY:0]   rd_pipe;    // Bit 0 lines up with READ on the pins

    assign sdram_dq  = dq_oe ? dq_out : 'z;
    assign sdram_cke = 1'b1;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= CMD_NOP;
            sdram_dqm <= '1;
            dq_oe     <= 1'b0;
            rd_pipe   <= '0;
            rvalid    <= 1'b0;
        end else begin
            {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= cmd_in.cmd;
            sdram_dqm <= cmd_in.dqm;
            dq_oe     <= cmd_in.drive;      // Only for the WRITE cycle
            rd_pipe   <= {rd_pipe[CAS_LATENCY-1:0], cmd_in.rd_issue};
            rvalid    <= rd_pipe[CAS_LATENCY];
        end
    end

    always_ff @(posedge clk) begin
        sdram_a  <= cmd_in.a;
        sdram_ba <= cmd_in.ba;
        dq_out   <= cmd_in.wdata;
        if (rd_pipe[CAS_LATENCY]) begin
            rdata <= sdram_dq;      // Data valid CL cycles after the SDRAM sees READ
        end
    end

    read_no_drive_a: assert property (@(posedge clk) disable iff (!resetn)
        cmd_in.rd_issue |=>
            ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == CMD_READ) && !dq_oe);

endmodule

/* verilog/sdram_ctrl.sv */
// Top level of the CL2 SDRAM controller, host req/ack port on one side and SDRAM pins on the other
`timescale 1ns/1ps

module sdram_ctrl #(
    parameter int CAS_LATENCY      = 2,
    parameter int T_RP             = 2,
    parameter int T_RCD            = 2,
    parameter int T_RC             = 6,
    parameter int T_WR             = 2,
    parameter int T_MRD            = 2,
    parameter int REFRESH_INTERVAL = 501
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req,
    input  logic                          we,
    input  logic [sdram_pkg::HADDR_W-1:0] addr,
    input  logic [sdram_pkg::DATA_W-1:0]  wdata,
    input  logic [sdram_pkg::DQM_W-1:0]   ds,
    output logic                          ack,
    output logic [sdram_pkg::DATA_W-1:0]  rdata,
    output logic                          rvalid,
    inout  wire  [sdram_pkg::DATA_W-1:0]  sdram_dq,
    output logic [sdram_pkg::ROW_W-1:0]   sdram_a,
    output logic [sdram_pkg::BANK_W-1:0]  sdram_ba,
    output logic [sdram_pkg::DQM_W-1:0]   sdram_dqm,
    output logic                          sdram_cs_n,
    output logic                          sdram_ras_n,
    output logic                          sdram_cas_n,
    output logic                          sdram_we_n,
    output logic                          sdram_cke
);

    req_bus req_if ();
    cmd_bus cmd_if ();

    host_port host_port_i (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .ds     (ds),
        .ack    (ack),
        .bus    (req_if.source)
    );

    sdram_sequencer #(
        .CAS_LATENCY      (CAS_LATENCY),
        .T_RP             (T_RP),
        .T_RCD            (T_RCD),
        .T_RC             (T_RC),
        .T_WR             (T_WR),
        .T_MRD            (T_MRD),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) sequencer_i (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req_if.sink),
        .cmd_out (cmd_if.source)
    );

    sdram_phy #(
        .CAS_LATENCY (CAS_LATENCY)
    ) phy_i (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_in      (cmd_if.sink),
        .sdram_dq    (sdram_dq),
        .sdram_a     (sdram_a),
        .sdram_ba    (sdram_ba),
        .sdram_dqm   (sdram_dqm),
        .sdram_cs_n  (sdram_cs_n),
        .sdram_ras_n (sdram_ras_n),
        .sdram_cas_n (sdram_cas_n),
        .sdram_we_n  (sdram_we_n),
        .sdram_cke   (sdram_cke),
        .rdata       (rdata),
        .rvalid      (rvalid)
    );

endmodule

/* tests/sdram_model.sv */
// Behavioural CL2 SDRAM for the controller testbench, stores data and flags protocol faults
`timescale 1ns/1ps

module sdram_model (
    input  logic                         clk,
    inout  wire  [sdram_pkg::DATA_W-1:0] dq,
    input  logic [sdram_pkg::ROW_W-1:0]  a,
    input  logic [sdram_pkg::BANK_W-1:0] ba,
    input  logic [sdram_pkg::DQM_W-1:0]  dqm,
    input  logic                         cs_n,
    input  logic                         ras_n,
    input  logic                         cas_n,
    input  logic                         we_n,
    input  logic                         cke,
    output int                           faults
);
    import sdram_pkg::*;

    logic [DATA_W-1:0] mem [int];
    logic              bank_open [4];
    logic [ROW_W-1:0]  open_row [4];
    logic [3:0]        cmd;
    logic              rd_v1;
    logic [DATA_W-1:0] rd_d1;
    logic              out_en;
    logic [DATA_W-1:0] out_data;
    logic [DATA_W-1:0] word;
    int                idx;

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = out_en ? out_data : 'z;

    initial begin
        faults = 0;
        out_en = 1'b0;
        rd_v1  = 1'b0;
        for (int b = 0; b < 4; b++) begin
            bank_open[b] = 1'b0;
        end
    end

    always @(posedge clk) begin
        out_en   <= rd_v1;      // Data on DQ for the edge CL cycles after READ
        out_data <= rd_d1;
        rd_v1    <= 1'b0;
        assert (cke) else begin
            faults++;
            $display("model: clock enable went low");
        end
        case (cmd)
            CMD_ACTIVE: begin
                assert (!bank_open[ba]) else begin
                    faults++;
                    $display("model: ACTIVE to bank %0d which is still open", ba);
                end
                bank_open[ba] = 1'b1;
                open_row[ba]  = a;
            end
            CMD_READ, CMD_WRITE: begin
                assert (bank_open[ba]) else begin
                    faults++;
                    $display("model: access to bank %0d without ACTIVE", ba);
                end
                idx  = int'({ba, open_row[ba], a[COL_W-1:0]});
                word = mem.exists(idx) ? mem[idx] : '0;
                if (cmd == CMD_WRITE) begin
                    for (int b = 0; b < DQM_W; b++) begin
                        if (!dqm[b]) word[8*b +: 8] = dq[8*b +: 8];
                    end
                    mem[idx] = word;
                end else begin
                    rd_v1 <= 1'b1;
                    rd_d1 <= word;
                end
                if (a[10]) bank_open[ba] = 1'b0;    // Auto-precharge
            end
            CMD_PRECHARGE: begin
                for (int b = 0; b < 4; b++) begin
                    if (a[10] || b == int'(ba)) bank_open[b] = 1'b0;
                end
            end
            CMD_REFRESH: begin
                assert (!(bank_open[0] || bank_open[1] || bank_open[2] || bank_open[3]))
                else begin
                    faults++;
                    $display("model: REFRESH while a bank is open");
                end
            end
            default: ;
        endcase
    end

endmodule

/* tests/tb_sdram_ctrl.sv */
// Testbench for the SDRAM controller, runs a request table against a CL2 SDRAM model
`timescale 1ns/1ps

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int TABLE_LEN       = 24;
    localparam int TIMEOUT_CYCLES  = 300 + 40 * TABLE_LEN;
    localparam int REFRESH_GAP_MAX = 60 + 16;   // Interval plus the longest access

    logic               clk;
    logic               resetn;
    logic               req;
    logic               we;
    logic [HADDR_W-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [DQM_W-1:0]   ds;
    logic               ack;
    logic [DATA_W-1:0]  rdata;
    logic               rvalid;
    wire  [DATA_W-1:0]  sdram_dq;
    logic [ROW_W-1:0]   sdram_a;
    logic [BANK_W-1:0]  sdram_ba;
    logic [DQM_W-1:0]   sdram_dqm;
    logic               sdram_cs_n;
    logic               sdram_ras_n;
    logic               sdram_cas_n;
    logic               sdram_we_n;
    logic               sdram_cke;

    int                 errors;
    int                 model_faults;
    int                 cycles;
    int                 init_seen;
    int                 ref_gap;
    logic               mode_seen;
    logic [3:0]         pin_cmd;
    logic [3:0]         init_exp [4];
    sdram_a_u           mode_word;
    logic [15:0]        lfsr;
    logic [DATA_W-1:0]  shadow [int];
    logic [DATA_W-1:0]  expect_q [$];
    logic [DATA_W-1:0]  exp_word;

    logic               t_we   [TABLE_LEN];
    logic [HADDR_W-1:0] t_addr [TABLE_LEN];
    logic [DATA_W-1:0]  t_data [TABLE_LEN];
    logic [DQM_W-1:0]   t_ds   [TABLE_LEN];
    logic               t_rnd  [TABLE_LEN];

    sdram_ctrl #(
        .T_RC             (6),
        .REFRESH_INTERVAL (60)
    ) dut_i (
        .clk (clk), .resetn (resetn), .req (req), .we (we), .addr (addr),
        .wdata (wdata), .ds (ds), .ack (ack), .rdata (rdata), .rvalid (rvalid),
        .sdram_dq (sdram_dq), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
        .sdram_dqm (sdram_dqm), .sdram_cs_n (sdram_cs_n), .sdram_ras_n (sdram_ras_n),
        .sdram_cas_n (sdram_cas_n), .sdram_we_n (sdram_we_n), .sdram_cke (sdram_cke)
    );

    sdram_model mem_i (
        .clk (clk), .dq (sdram_dq), .a (sdram_a), .ba (sdram_ba), .dqm (sdram_dqm),
        .cs_n (sdram_cs_n), .ras_n (sdram_ras_n), .cas_n (sdram_cas_n),
        .we_n (sdram_we_n), .cke (sdram_cke), .faults (model_faults)
    );

    always #10 clk = ~clk;

    assign pin_cmd = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [DQM_W-1:0]  lanes);
        logic [DATA_W-1:0] w;
        w = old_w;
        for (int b = 0; b < DQM_W; b++) begin
            if (lanes[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    task automatic random_word(output logic [DATA_W-1:0] w);
        w = '0;
        for (int b = 0; b < DATA_W; b++) begin
            lfsr = lfsr_step(lfsr);     // One step per bit
            w    = {w[DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic set_entry(input int i, input logic w, input int bk, input int row,
                             input int col, input logic [DATA_W-1:0] d,
                             input logic [DQM_W-1:0] lanes, input logic rnd);
        t_we[i]   = w;
        t_addr[i] = {BANK_W'(bk), ROW_W'(row), COL_W'(col)};
        t_data[i] = d;
        t_ds[i]   = lanes;
        t_rnd[i]  = rnd;
    endtask

    task automatic fill_table();
        set_entry(0,  1, 0, 5,    3,   16'h1234, 2'b11, 0);
        set_entry(1,  0, 0, 5,    3,   16'h0000, 2'b11, 0);
        set_entry(2,  1, 1, 100,  7,   16'h0000, 2'b11, 1);
        set_entry(3,  0, 1, 100,  7,   16'h0000, 2'b11, 0);
        set_entry(4,  1, 0, 5,    3,   16'h5a5a, 2'b01, 0);  // Low lane only
        set_entry(5,  0, 0, 5,    3,   16'h0000, 2'b11, 0);
        set_entry(6,  1, 0, 5,    3,   16'hc3c3, 2'b10, 0);
        set_entry(7,  0, 0, 5,    3,   16'h0000, 2'b11, 0);
        set_entry(8,  1, 2, 8191, 511, 16'h0000, 2'b11, 1);
        set_entry(9,  1, 3, 0,    0,   16'h0000, 2'b11, 1);
        set_entry(10, 1, 2, 9,    511, 16'h0000, 2'b11, 1);  // Same bank, other row
        set_entry(11, 0, 2, 8191, 511, 16'h0000, 2'b11, 0);
        set_entry(12, 0, 3, 0,    0,   16'h0000, 2'b11, 0);
        set_entry(13, 0, 2, 9,    511, 16'h0000, 2'b11, 0);
        set_entry(14, 1, 3, 0,    0,   16'h0000, 2'b10, 1);
        set_entry(15, 0, 3, 0,    0,   16'h0000, 2'b11, 0);
        set_entry(16, 1, 1, 100,  8,   16'h0000, 2'b01, 1);
        set_entry(17, 0, 1, 100,  8,   16'h0000, 2'b11, 0);
        set_entry(18, 0, 1, 100,  7,   16'h0000, 2'b11, 0);
        set_entry(19, 1, 0, 1,    1,   16'h0000, 2'b11, 1);
        set_entry(20, 1, 0, 1,    2,   16'h0000, 2'b11, 1);
        set_entry(21, 0, 0, 1,    1,   16'h0000, 2'b11, 0);
        set_entry(22, 0, 0, 1,    2,   16'h0000, 2'b11, 0);
        set_entry(23, 0, 0, 5,    3,   16'h0000, 2'b11, 0);
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        ds          = '0;
        errors      = 0;
        cycles      = 0;
        init_seen   = 0;
        ref_gap     = 0;
        mode_seen   = 1'b0;
        lfsr        = 16'd27;
        init_exp[0] = CMD_PRECHARGE;
        init_exp[1] = CMD_REFRESH;
        init_exp[2] = CMD_REFRESH;
        init_exp[3] = CMD_MODE;
        fill_table();

        repeat (16) @(posedge clk);
        #2 resetn = 1'b1;

        wait (mode_seen);               // Host stays idle until the mode register is set
        #2;

        for (int i = 0; i < TABLE_LEN; i++) begin
            we   = t_we[i];
            addr = t_addr[i];
            ds   = t_ds[i];
            if (t_rnd[i]) random_word(wdata);
            else wdata = t_data[i];
            req = 1'b1;
            do @(posedge clk); while (!ack);
            exp_word = shadow.exists(int'(addr)) ? shadow[int'(addr)] : '0;
            if (we) shadow[int'(addr)] = merge_lanes(exp_word, wdata, ds);
            else expect_q.push_back(exp_word);
            #2;                         // Next request right behind the ack
        end
        req = 1'b0;

        while (expect_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);

        $display("errors %0d, model faults %0d", errors, model_faults);
        if (errors == 0 && model_faults == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Pin monitor for init order, ack timing and refresh spacing
    always @(posedge clk) begin
        if (resetn) begin
            if (pin_cmd != CMD_NOP && init_seen < 4) begin
                assert (pin_cmd == init_exp[init_seen]) else begin
                    errors++;
                    $display("mismatch init cmd %0d: got %h expected %h",
                             init_seen, pin_cmd, init_exp[init_seen]);
                end
                if (pin_cmd == CMD_PRECHARGE) begin
                    assert (sdram_a[10]) else begin
                        errors++;
                        $display("mismatch sdram_a on PRECHARGE: got %h", sdram_a);
                    end
                end
                if (pin_cmd == CMD_MODE) begin
                    mode_word = sdram_a;
                    mode_seen = 1'b1;
                    assert (mode_word.mode.cas_lat == 3'd2 && mode_word.mode.burst_len == 3'd0)
                    else begin
                        errors++;
                        $display("mismatch sdram_a on MODE: got %h", sdram_a);
                    end
                end
                init_seen++;
            end
            assert (!(ack && !mode_seen)) else begin
                errors++;
                $display("ack arrived before the mode register was set");
            end
            if (mode_seen) begin
                ref_gap = (pin_cmd == CMD_REFRESH) ? 0 : ref_gap + 1;
                assert (ref_gap <= REFRESH_GAP_MAX) else begin
                    errors++;
                    $display("no refresh for %0d cycles", ref_gap);
                end
            end
            if (rvalid) begin
                assert (expect_q.size() != 0) else begin
                    errors++;
                    $display("rvalid with no read outstanding");
                end
                if (expect_q.size() != 0) begin
                    assert (rdata == expect_q[0]) else begin
                        errors++;
                        $display("mismatch rdata: got %h expected %h", rdata, expect_q[0]);
                    end
                    void'(expect_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

/* compile.f */
verilog/sdram_pkg.sv
verilog/sdram_ifs.sv
verilog/host_port.sv
verilog/init_sequencer.sv
verilog/sdram_sequencer.sv
verilog/sdram_phy.sv
verilog/sdram_ctrl.sv
tests/sdram_model.sv
tests/tb_sdram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_sdram_ctrl -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
